// ==== logic/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define CPU_XLEN     64            // Data path width
`define CPU_ILEN     32            // Instruction width
`define CPU_REG_BITS 5             // 32 architectural registers
`define CPU_ZERO_REG 5'd31         // Reads as zero and is never written

// Opcode field is instr[31:21]
`define CPU_OP_ADD   11'b10001011000
`define CPU_OP_SUB   11'b11001011000
`define CPU_OP_AND   11'b10001010000
`define CPU_OP_ORR   11'b10101010000
`define CPU_OP_LDUR  11'b11111000010
`define CPU_OP_STUR  11'b11111000000

`define CPU_ALU_AND  4'b0000
`define CPU_ALU_ORR  4'b0001
`define CPU_ALU_ADD  4'b0010       // Also address generation
`define CPU_ALU_SUB  4'b0110

`endif

// ==== logic/cpu_pkg.sv ====
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

  // Data values, addresses and the program counter
  typedef logic [`CPU_XLEN-1:0]     word_t;

  typedef logic [`CPU_ILEN-1:0]     instr_t;    // One fetched instruction

  typedef logic [`CPU_REG_BITS-1:0] reg_idx_t;  // Register number

  typedef logic [10:0]              opcode_t;   // instr[31:21]

  typedef logic [3:0]               alu_sel_t;  // See CPU_ALU_* codes

  // Where an execute operand comes from
  typedef logic [1:0]               fwd_sel_t;

endpackage

`default_nettype wire

// ==== logic/pipe_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface id_ex_if;
  import cpu_pkg::*;

  alu_sel_t alu_sel;
  logic     alu_src;      // Second operand is the immediate
  logic     mem_read;
  logic     mem_write;
  logic     reg_write;
  logic     mem_to_reg;
  word_t    rn_data;
  word_t    rm_data;      // Rt value for a store
  word_t    imm;
  reg_idx_t rd;
  reg_idx_t rn;
  reg_idx_t rm;

  modport stage_out (output alu_sel, alu_src, mem_read, mem_write, reg_write, mem_to_reg,
                     output rn_data, rm_data, imm, rd, rn, rm);

  modport stage_in  (input alu_sel, alu_src, mem_read, mem_write, reg_write, mem_to_reg,
                     input rn_data, rm_data, imm, rd, rn, rm);
endinterface

interface ex_mem_if;
  import cpu_pkg::*;

  logic     mem_read;
  logic     mem_write;
  logic     reg_write;
  logic     mem_to_reg;
  word_t    alu_result;   // Memory address for loads and stores
  word_t    store_data;
  reg_idx_t rd;

  modport stage_out (output mem_read, mem_write, reg_write, mem_to_reg,
                     output alu_result, store_data, rd);

  modport stage_in  (input mem_read, mem_write, reg_write, mem_to_reg,
                     input alu_result, store_data, rd);
endinterface

`default_nettype wire

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
  input  wire                  CLOCK,
  input  wire                  rst_n,
  input  wire                  stall,       // Load-use hold from decode
  input  wire cpu_pkg::instr_t instr,
  output cpu_pkg::word_t       pc,
  output cpu_pkg::instr_t      ifid_instr
);
  import cpu_pkg::*;

  localparam word_t pc_step = word_t'(4);

  // PC and IF/ID move together so a stall freezes both
  always_ff @(posedge CLOCK) begin
    if (!rst_n) begin
      pc         <= '0;
      ifid_instr <= '0;              // Opcode zero decodes as NOP
    end else if (!stall) begin
      pc         <= pc + pc_step;
      ifid_instr <= instr;
    end
  end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_cfg.svh"

module reg_file (
  input  wire                    CLOCK,
  input  wire                    rst_n,
  input  wire cpu_pkg::reg_idx_t rn,
  input  wire cpu_pkg::reg_idx_t rm,
  output cpu_pkg::word_t         rn_data,
  output cpu_pkg::word_t         rm_data,
  input  wire                    wb_en,
  input  wire cpu_pkg::reg_idx_t wb_reg,
  input  wire cpu_pkg::word_t    wb_data
);
  import cpu_pkg::*;

  word_t regs [2**`CPU_REG_BITS];

  always_ff @(posedge CLOCK) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**`CPU_REG_BITS; i++) begin
        regs[i] <= word_t'(i);       // Register i starts at i
      end
    end else if (wb_en) begin
      regs[wb_reg] <= wb_data;       // Decode never enables x31
    end
  end

  // Same-cycle writeback bypasses the array
  assign rn_data = (rn == `CPU_ZERO_REG)        ? '0      :
                   (wb_en && (wb_reg == rn))    ? wb_data : regs[rn];
  assign rm_data = (rm == `CPU_ZERO_REG)        ? '0      :
                   (wb_en && (wb_reg == rm))    ? wb_data : regs[rm];

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_cfg.svh"

module decode_stage (
  input  wire                    CLOCK,
  input  wire                    rst_n,
  input  wire cpu_pkg::instr_t   ifid_instr,
  output logic                   stall,
  input  wire                    wb_en,
  input  wire cpu_pkg::reg_idx_t wb_reg,
  input  wire cpu_pkg::word_t    wb_data,
  id_ex_if.stage_out             ex
);
  import cpu_pkg::*;

  opcode_t  opcode;
  reg_idx_t rd;
  reg_idx_t rn;
  reg_idx_t rm;
  reg_idx_t rm_sel;
  word_t    rn_data;
  word_t    rm_data;
  word_t    imm;
  alu_sel_t alu_sel;
  logic     is_r;
  logic     is_ld;
  logic     is_st;
  logic     uses_rn;
  logic     uses_rm;
  logic     reg_write;

  assign opcode = ifid_instr[31:21];
  assign rd     = ifid_instr[4:0];
  assign rn     = ifid_instr[9:5];
  assign rm     = ifid_instr[20:16];
  assign rm_sel = is_st ? rd : rm;                       // Store data is Rt
  assign imm    = {{(`CPU_XLEN-9){ifid_instr[20]}}, ifid_instr[20:12]};

  always_comb begin
    is_r    = 1'b0;
    is_ld   = 1'b0;
    is_st   = 1'b0;
    alu_sel = '0;                                        // Unknown opcode is a NOP
    case (opcode)
      `CPU_OP_ADD:  begin is_r  = 1'b1; alu_sel = `CPU_ALU_ADD; end
      `CPU_OP_SUB:  begin is_r  = 1'b1; alu_sel = `CPU_ALU_SUB; end
      `CPU_OP_AND:  begin is_r  = 1'b1; alu_sel = `CPU_ALU_AND; end
      `CPU_OP_ORR:  begin is_r  = 1'b1; alu_sel = `CPU_ALU_ORR; end
      `CPU_OP_LDUR: begin is_ld = 1'b1; alu_sel = `CPU_ALU_ADD; end
      `CPU_OP_STUR: begin is_st = 1'b1; alu_sel = `CPU_ALU_ADD; end
      default:      ;
    endcase
  end

  assign reg_write = (is_r | is_ld) && (rd != `CPU_ZERO_REG);
  assign uses_rn   = is_r | is_ld | is_st;
  assign uses_rm   = is_r | is_st;

  // Load in execute feeding this instruction
  assign stall = ex.mem_read && ((uses_rn && (ex.rd == rn)) || (uses_rm && (ex.rd == rm_sel)));

  reg_file i_reg_file (
    .CLOCK   (CLOCK),
    .rst_n   (rst_n),
    .rn      (rn),
    .rm      (rm_sel),
    .rn_data (rn_data),
    .rm_data (rm_data),
    .wb_en   (wb_en),
    .wb_reg  (wb_reg),
    .wb_data (wb_data)
  );

  always_ff @(posedge CLOCK) begin
    if (!rst_n || stall) begin                           // Bubble on stall
      ex.alu_sel    <= '0;
      ex.alu_src    <= 1'b0;
      ex.mem_read   <= 1'b0;
      ex.mem_write  <= 1'b0;
      ex.reg_write  <= 1'b0;
      ex.mem_to_reg <= 1'b0;
    end else begin
      ex.alu_sel    <= alu_sel;
      ex.alu_src    <= is_ld | is_st;
      ex.mem_read   <= is_ld;
      ex.mem_write  <= is_st;
      ex.reg_write  <= reg_write;
      ex.mem_to_reg <= is_ld;
    end
  end

  always_ff @(posedge CLOCK) begin
    ex.rn_data <= rn_data;
    ex.rm_data <= rm_data;
    ex.imm     <= imm;
    ex.rd      <= rd;
    ex.rn      <= rn;
    ex.rm      <= rm_sel;                                // Forwarding key for store data
  end

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_cfg.svh"

module execute_stage (
  input  wire                    CLOCK,
  input  wire                    rst_n,
  id_ex_if.stage_in              id,
  ex_mem_if.stage_out            mem,
  input  wire                    wb_en,
  input  wire cpu_pkg::reg_idx_t wb_reg,
  input  wire cpu_pkg::word_t    wb_data
);
  import cpu_pkg::*;

  localparam fwd_sel_t fwd_reg = 2'd0;
  localparam fwd_sel_t fwd_mem = 2'd1;
  localparam fwd_sel_t fwd_wb  = 2'd2;

  fwd_sel_t fwd_a;
  fwd_sel_t fwd_b;
  word_t    op_a;
  word_t    rm_val;
  word_t    op_b;
  word_t    result;

  function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val,
                                    input word_t mem_val, input word_t wb_val);
    case (sel)
      fwd_mem: return mem_val;
      fwd_wb:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  // Memory stage is newer so it is checked first
  assign fwd_a = (mem.reg_write && (mem.rd == id.rn)) ? fwd_mem :
                 (wb_en && (wb_reg == id.rn))          ? fwd_wb  : fwd_reg;
  assign fwd_b = (mem.reg_write && (mem.rd == id.rm)) ? fwd_mem :
                 (wb_en && (wb_reg == id.rm))          ? fwd_wb  : fwd_reg;

  assign op_a   = fwd_mux(fwd_a, id.rn_data, mem.alu_result, wb_data);
  assign rm_val = fwd_mux(fwd_b, id.rm_data, mem.alu_result, wb_data);
  assign op_b   = id.alu_src ? id.imm : rm_val;

  always_comb begin
    case (id.alu_sel)
      `CPU_ALU_AND: result = op_a & op_b;
      `CPU_ALU_ORR: result = op_a | op_b;
      `CPU_ALU_ADD: result = op_a + op_b;
      `CPU_ALU_SUB: result = op_a - op_b;
      default:      result = '0;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (!rst_n) begin
      mem.mem_read   <= 1'b0;
      mem.mem_write  <= 1'b0;
      mem.reg_write  <= 1'b0;
      mem.mem_to_reg <= 1'b0;
    end else begin
      mem.mem_read   <= id.mem_read;
      mem.mem_write  <= id.mem_write;
      mem.reg_write  <= id.reg_write;
      mem.mem_to_reg <= id.mem_to_reg;
    end
  end

  always_ff @(posedge CLOCK) begin
    mem.alu_result <= result;
    mem.store_data <= rm_val;        // Forwarded Rt
    mem.rd         <= id.rd;
  end

endmodule

`default_nettype wire

// ==== logic/mem_wb_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_wb_stage (
  input  wire                 CLOCK,
  input  wire                 rst_n,
  ex_mem_if.stage_in          mem,
  input  wire cpu_pkg::word_t mem_rdata,   // Valid while mem_read is high
  output logic                wb_en,
  output cpu_pkg::reg_idx_t   wb_reg,
  output cpu_pkg::word_t      wb_data
);
  import cpu_pkg::*;

  logic  mem_to_reg_q;
  word_t alu_result_q;
  word_t load_data_q;

  always_ff @(posedge CLOCK) begin
    if (!rst_n) begin
      wb_en        <= 1'b0;
      mem_to_reg_q <= 1'b0;
    end else begin
      wb_en        <= mem.reg_write;
      mem_to_reg_q <= mem.mem_to_reg;
    end
  end

  always_ff @(posedge CLOCK) begin
    alu_result_q <= mem.alu_result;
    load_data_q  <= mem_rdata;
    wb_reg       <= mem.rd;
  end

  assign wb_data = mem_to_reg_q ? load_data_q : alu_result_q;

endmodule

`default_nettype wire

// ==== logic/cpu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
  input  wire                    CLOCK,
  input  wire                    rst_n,
  output cpu_pkg::word_t         pc,
  input  wire cpu_pkg::instr_t   instr,
  output cpu_pkg::word_t         mem_addr,
  output cpu_pkg::word_t         mem_wdata,
  output logic                   mem_read,
  output logic                   mem_write,
  input  wire cpu_pkg::word_t    mem_rdata,
  output logic                   wb_en,
  output cpu_pkg::reg_idx_t      wb_reg,
  output cpu_pkg::word_t         wb_data
);
  import cpu_pkg::*;

  instr_t ifid_instr;
  logic   stall;

  id_ex_if  id_ex ();
  ex_mem_if ex_mem ();

  fetch_stage i_fetch (.CLOCK(CLOCK), .rst_n(rst_n), .stall(stall), .instr(instr),
                       .pc(pc), .ifid_instr(ifid_instr));

  decode_stage i_decode (.CLOCK(CLOCK), .rst_n(rst_n), .ifid_instr(ifid_instr),
                         .stall(stall), .wb_en(wb_en), .wb_reg(wb_reg),
                         .wb_data(wb_data), .ex(id_ex.stage_out));

  execute_stage i_execute (.CLOCK(CLOCK), .rst_n(rst_n), .id(id_ex.stage_in),
                           .mem(ex_mem.stage_out), .wb_en(wb_en), .wb_reg(wb_reg),
                           .wb_data(wb_data));

  mem_wb_stage i_mem_wb (.CLOCK(CLOCK), .rst_n(rst_n), .mem(ex_mem.stage_in),
                         .mem_rdata(mem_rdata), .wb_en(wb_en), .wb_reg(wb_reg),
                         .wb_data(wb_data));

  // Data memory sits on the EX/MEM register
  assign mem_addr  = ex_mem.alu_result;
  assign mem_wdata = ex_mem.store_data;
  assign mem_read  = ex_mem.mem_read;
  assign mem_write = ex_mem.mem_write;

endmodule

`default_nettype wire

// ==== dv/cpu_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_props (
  input wire                    CLOCK,
  input wire                    rst_n,
  input wire                    mem_read,
  input wire                    mem_write,
  input wire                    wb_en,
  input wire cpu_pkg::reg_idx_t wb_reg
);
  a_no_rw_overlap: assert property (@(posedge CLOCK) disable iff (!rst_n)
    !(mem_read && mem_write))
    else $error("mem_read and mem_write high together");

  a_no_zero_wb: assert property (@(posedge CLOCK) disable iff (!rst_n)
    wb_en |-> (wb_reg != 5'd31))
    else $error("writeback to x31");

  // Strobes are quiet one cycle into reset
  a_reset_quiet: assert property (@(posedge CLOCK)
    !rst_n |=> (!mem_read && !mem_write && !wb_en))
    else $error("strobe active after reset");
endmodule

bind cpu_top cpu_props i_props (.CLOCK(CLOCK), .rst_n(rst_n), .mem_read(mem_read),
                                .mem_write(mem_write), .wb_en(wb_en), .wb_reg(wb_reg));

`default_nettype wire

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic CLOCK,
  output logic rst_n
);
  initial begin
    CLOCK = 1'b0;
    forever #4 CLOCK = ~CLOCK;             // 8 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge CLOCK);
    @(negedge CLOCK);
    rst_n = 1'b1;
  end
endmodule

`default_nettype wire

// ==== dv/tb_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_cfg.svh"

module tb_top;
  import cpu_pkg::*;

  localparam int cycle_limit = 2 * (8 + 6 + 3 + 6) + 4 * 20;

  logic        CLOCK;
  logic        clk_rst_n;
  logic        test_rst_n;
  logic        dut_rst_n;
  word_t       pc, mem_addr, mem_wdata, mem_rdata, wb_data, prev_pc;
  instr_t      instr;
  logic        mem_read, mem_write, wb_en, live;
  reg_idx_t    wb_reg;
  instr_t      prog[$];
  word_t       dmem[128];
  word_t       mmem[128];                  // Reference model memory
  logic [68:0] exp_wb[$], obs_wb[$];       // {rd, data}
  logic [127:0] exp_st[$], obs_st[$];      // {addr, data}
  int          holds, errors, checks, cycles, fetch_idx;
  logic [31:0] lfsr;

  assign dut_rst_n = clk_rst_n & test_rst_n;

  tb_clock i_clock (.CLOCK(CLOCK), .rst_n(clk_rst_n));

  cpu_top i_dut (.CLOCK(CLOCK), .rst_n(dut_rst_n), .pc(pc), .instr(instr),
                 .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_read(mem_read),
                 .mem_write(mem_write), .mem_rdata(mem_rdata), .wb_en(wb_en),
                 .wb_reg(wb_reg), .wb_data(wb_data));

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
  endfunction

  function automatic instr_t r_op(input opcode_t op, input int rd, input int rn, input int rm);
    return {op, 5'(rm), 6'd0, 5'(rn), 5'(rd)};
  endfunction

  function automatic instr_t d_op(input opcode_t op, input int rt, input int rn, input int off);
    return {op, 9'(off), 2'd0, 5'(rn), 5'(rt)};
  endfunction

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", what, got, exp);
    end
  endtask

  always @(posedge CLOCK) begin
    live <= dut_rst_n;
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the pipeline never drained", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  // Instruction and data memory models
  always @(negedge CLOCK) begin
    fetch_idx = int'(pc >> 2);
    instr     <= (fetch_idx < prog.size()) ? prog[fetch_idx] : '0;
    mem_rdata <= mem_read ? dmem[mem_addr[9:3]] : '0;
    if (live) begin
      if (pc == prev_pc) holds++;
      if (wb_en) obs_wb.push_back({wb_reg, wb_data});
      if (mem_write) begin
        obs_st.push_back({mem_addr, mem_wdata});
        dmem[mem_addr[9:3]] = mem_wdata;
      end
    end
    prev_pc = pc;
  end

  // In-order execution of prog against mmem
  task automatic model_run();
    word_t r[32];
    word_t a, b, v, addr;
    instr_t ins;
    int rd, rn, rm;
    logic wr;
    for (int i = 0; i < 32; i++) r[i] = word_t'(i);
    foreach (prog[k]) begin
      ins  = prog[k];
      rd   = int'(ins[4:0]);
      rn   = int'(ins[9:5]);
      rm   = int'(ins[20:16]);
      a    = (rn == 31) ? '0 : r[rn];
      b    = (rm == 31) ? '0 : r[rm];
      addr = a + {{55{ins[20]}}, ins[20:12]};
      wr   = 1'b1;
      case (ins[31:21])
        `CPU_OP_ADD:  v = a + b;
        `CPU_OP_SUB:  v = a - b;
        `CPU_OP_AND:  v = a & b;
        `CPU_OP_ORR:  v = a | b;
        `CPU_OP_LDUR: v = mmem[addr[9:3]];
        `CPU_OP_STUR: begin
          wr = 1'b0;
          v  = (rd == 31) ? '0 : r[rd];
          exp_st.push_back({addr, v});
          mmem[addr[9:3]] = v;
        end
        default: wr = 1'b0;
      endcase
      if (wr && rd != 31) begin
        r[rd] = v;
        exp_wb.push_back({5'(rd), v});
      end
    end
  endtask

  task automatic run_test(input string name, input int exp_holds);
    word_t w;
    for (int i = 0; i < 128; i++) begin
      w = '0;
      for (int j = 0; j < 64; j++) begin
        lfsr = lfsr_next(lfsr);
        w    = {w[62:0], lfsr[0]};
      end
      dmem[i] = w;
    end
    mmem = dmem;
    exp_wb.delete();
    exp_st.delete();
    model_run();
    @(negedge CLOCK);
    test_rst_n = 1'b0;
    repeat (3) @(negedge CLOCK);
    check({name, " pc"}, pc, '0);
    check({name, " mem_read"}, 64'(mem_read), '0);
    check({name, " mem_write"}, 64'(mem_write), '0);
    check({name, " wb_en"}, 64'(wb_en), '0);
    obs_wb.delete();
    obs_st.delete();
    holds      = 0;
    test_rst_n = 1'b1;
    while (int'(pc >> 2) < prog.size() + 6) @(negedge CLOCK);
    check({name, " wb count"}, 64'(obs_wb.size()), 64'(exp_wb.size()));
    for (int i = 0; i < obs_wb.size() && i < exp_wb.size(); i++) begin
      check({name, " wb_reg"}, 64'(obs_wb[i][68:64]), 64'(exp_wb[i][68:64]));
      check({name, " wb_data"}, obs_wb[i][63:0], exp_wb[i][63:0]);
    end
    check({name, " store count"}, 64'(obs_st.size()), 64'(exp_st.size()));
    for (int i = 0; i < obs_st.size() && i < exp_st.size(); i++) begin
      check({name, " mem_addr"}, obs_st[i][127:64], exp_st[i][127:64]);
      check({name, " mem_wdata"}, obs_st[i][63:0], exp_st[i][63:0]);
    end
    check({name, " pc holds"}, 64'(holds), 64'(exp_holds));
  endtask

  task automatic alu_ops();
    prog = {r_op(`CPU_OP_ADD, 1, 2, 3), 32'd0, r_op(`CPU_OP_SUB, 4, 20, 5), 32'd0,
            r_op(`CPU_OP_AND, 6, 7, 13), 32'd0, r_op(`CPU_OP_ORR, 8, 9, 12),
            r_op(`CPU_OP_ADD, 31, 10, 11)};
    run_test("alu", 0);
  endtask

  // Last ORR sees x1 in both Memory and Writeback
  task automatic forward_chains();
    prog = {r_op(`CPU_OP_ADD, 1, 2, 3), r_op(`CPU_OP_ADD, 4, 1, 5),
            r_op(`CPU_OP_ADD, 6, 1, 4), r_op(`CPU_OP_SUB, 1, 1, 2),
            r_op(`CPU_OP_ADD, 1, 1, 1), r_op(`CPU_OP_ORR, 7, 1, 12)};
    run_test("forward", 0);
  endtask

  task automatic load_use_stall();
    prog = {d_op(`CPU_OP_LDUR, 1, 8, 0), r_op(`CPU_OP_ADD, 2, 1, 3),
            r_op(`CPU_OP_ORR, 4, 2, 1)};
    run_test("load_use", 1);
  endtask

  task automatic store_reload();
    prog = {r_op(`CPU_OP_ADD, 1, 2, 3), d_op(`CPU_OP_STUR, 1, 16, -8),
            d_op(`CPU_OP_STUR, 9, 24, 16), d_op(`CPU_OP_LDUR, 10, 16, -8), 32'd0,
            r_op(`CPU_OP_ADD, 11, 10, 4)};
    run_test("store", 0);
  endtask

  initial begin
    test_rst_n = 1'b1;
    instr      = '0;
    mem_rdata  = '0;
    lfsr       = 32'hb0f2;
    live       = 1'b0;
    prev_pc    = '0;
    errors     = 0;
    checks     = 0;
    cycles     = 0;
    holds      = 0;
    wait (clk_rst_n);
    alu_ops();
    forward_chains();
    load_use_stall();
    store_reload();
    $display("Checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end
endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/pipe_if.sv
logic/fetch_stage.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/cpu_top.sv
dv/cpu_props.sv
dv/tb_clock.sv
dv/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_top \
  -Mdir obj_dir -o sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx ">>> PASS" sim.log; then
  exit 0
fi
exit 1
